// ==== filelist.f ====
+incdir+include
verilog/aesTypesPkg.sv
verilog/aesCtrlPkg.sv
verilog/invMixColumn.sv
verilog/invSbox.sv
verilog/invRoundData.sv
verilog/roundKeyStore.sv
verilog/decryptControl.sv
verilog/aesDecryptTop.sv
verification/aesRefPkg.sv
verification/aesDecryptTb.sv

// ==== include/aesDec_consts.svh ====
`ifndef AESDEC_CONSTS_SVH
`define AESDEC_CONSTS_SVH

// Width of one cipher block in bits.
`define AES_BLOCK_BITS 128

// Number of cipher rounds for a 128-bit key.
`define AES_ROUNDS 10

// One round key per round plus the initial AddRoundKey.
`define AES_NUM_KEYS 11

`endif

// ==== run.sh ====
#!/bin/sh
# Build the AES decryption testbench with Verilator and run it.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f filelist.f \
  --top-module aesDecryptTb -o simAesDecrypt

./obj_dir/simAesDecrypt > sim.log 2>&1
cat sim.log

if grep -q "Errors found" sim.log; then
  echo "Simulation failed"
  exit 1
fi
echo "Simulation passed"

// ==== verification/aesDecryptTb.sv ====
`timescale 1ns/1ns
`include "aesDec_consts.svh"

module aesDecryptTb;
  import aesTypesPkg::*;
  import aesRefPkg::*;

  localparam int NumRows    = 6;
  localparam int MaxHold    = 4;
  localparam int Latency    = `AES_ROUNDS;
  localparam int AckLimit   = 40;  // Cycles to wait for ack before giving up.
  localparam int WatchdogNs = NumRows * (`AES_NUM_KEYS + 14 + MaxHold) * 10 * 2;

  typedef struct {
    string  name;
    block_t key;
    block_t plain;
    int     hold;  // Extra cycles with req high after ack.
  } testRow_t;

  logic           clk;
  logic           rstN;
  roundKeyWrite_t keyWr;
  logic           req;
  block_t         cipherIn;
  logic           ack;
  block_t         plainOut;

  testRow_t rows [NumRows];
  integer   seed = 79;
  int       errors;
  int       checks;

  aesDecryptTop dut_i (
    .clk      (clk),
    .rstN     (rstN),
    .keyWr    (keyWr),
    .req      (req),
    .cipherIn (cipherIn),
    .ack      (ack),
    .plainOut (plainOut)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    #(WatchdogNs);
    $display("Watchdog expired after %0d ns, the test sequence stalled", WatchdogNs);
    $display("Errors found");
    $finish;
  end

  // ####################################################################
  task automatic checkBlock(string name, block_t expected, block_t actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("FAIL %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic checkLatency(string name, int expected, int actual);
    checks++;
    if (actual != expected) begin
      errors++;
      $display("FAIL %s: expected %0d, actual %0d", name, expected, actual);
    end
  endtask

  task automatic checkFlag(string name, logic expected, logic actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("FAIL %s: expected %b, actual %b", name, expected, actual);
    end
  endtask

  // ####################################################################
  task automatic fillTable();
    rows[0].name  = "fips197C1";
    rows[0].key   = 128'h000102030405060708090a0b0c0d0e0f;
    rows[0].plain = 128'h00112233445566778899aabbccddeeff;
    rows[0].hold  = 2;
    for (int i = 1; i < NumRows; i++) begin
      rows[i].name = $sformatf("random%0d", i);
      for (int w = 0; w < 4; w++) begin
        rows[i].key[w]   = $random(seed);
        rows[i].plain[w] = $random(seed);
      end
      rows[i].hold = $unsigned($random(seed)) % (MaxHold + 1);
    end
    // Same plaintext as the row before it, under a fresh key.
    rows[NumRows - 1].name  = "rekey";
    rows[NumRows - 1].plain = rows[NumRows - 2].plain;
  endtask

  task automatic runRow(testRow_t row);
    keySched_t ks;
    block_t    cipher;
    int        cycles;
    ks     = expandKey(row.key);
    cipher = encryptBlock(row.plain, ks);
    for (int r = 0; r < `AES_NUM_KEYS; r++) begin
      @(posedge clk);
      keyWr.en  <= 1'b1;
      keyWr.idx <= keyIdx_t'(r);
      keyWr.key <= ks[r];
    end
    @(posedge clk);
    keyWr.en <= 1'b0;
    cipherIn <= cipher;
    req      <= 1'b1;

    @(posedge clk);  // E0 is the first edge that sees req high.
    cycles = 0;
    @(negedge clk);
    while (!ack && cycles < AckLimit) begin
      @(posedge clk);
      cycles++;
      @(negedge clk);
    end
    if (!ack) begin
      errors++;
      $display("Handshake for %s never completed, ack still low after %0d cycles",
               row.name, cycles);
      @(posedge clk);
      req <= 1'b0;
      return;
    end
    checkLatency({row.name, " latency"}, Latency, cycles);
    checkBlock(row.name, row.plain, plainOut);

    for (int h = 0; h < row.hold; h++) begin
      @(posedge clk);
      @(negedge clk);
      checkFlag({row.name, " ack held"}, 1'b1, ack);
      checkBlock({row.name, " held"}, row.plain, plainOut);
    end
    @(posedge clk);
    req <= 1'b0;
    @(negedge clk);
    checkFlag({row.name, " ack before release"}, 1'b1, ack);
    @(posedge clk);  // Ack falls here.
    @(negedge clk);
    checkFlag({row.name, " ack release"}, 1'b0, ack);
  endtask

  // ####################################################################
  initial begin
    rstN     = 1'b0;
    req      = 1'b0;
    keyWr    = '0;
    cipherIn = '0;
    errors   = 0;
    checks   = 0;
    fillTable();
    repeat (8) @(posedge clk);
    rstN <= 1'b1;
    @(negedge clk);
    checkFlag("reset ack", 1'b0, ack);
    checkBlock("model fips197C1", 128'h69c4e0d86a7b0430d8cdb78070b4c55a,
               encryptBlock(rows[0].plain, expandKey(rows[0].key)));

    for (int i = 0; i < NumRows; i++) begin
      runRow(rows[i]);
    end

    @(posedge clk);
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// ==== verification/aesRefPkg.sv ====
package aesRefPkg;
  import aesTypesPkg::*;

  // Round keys 0 to 10 of one AES-128 key.
  typedef block_t [0:10] keySched_t;

  function automatic byte_t mulX(byte_t b);
    return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
  endfunction

  // Shift-and-add product in GF(2^8).
  function automatic byte_t gfMultiply(byte_t a, byte_t b);
    byte_t acc;
    acc = '0;
    while (b != '0) begin
      if (b[0]) begin
        acc = acc ^ a;
      end
      a = mulX(a);
      b = b >> 1;
    end
    return acc;
  endfunction

  // Forward S-box. The inverse is found by search and zero stays zero.
  function automatic byte_t sboxFwd(byte_t a);
    byte_t inv;
    inv = '0;
    for (int x = 1; x < 256; x++) begin
      if (gfMultiply(a, byte_t'(x)) == 8'h01) begin
        inv = byte_t'(x);
      end
    end
    return inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]} ^
           {inv[4:0], inv[7:5]} ^ {inv[3:0], inv[7:4]} ^ 8'h63;
  endfunction

  function automatic column_t mixColumn(column_t a);
    column_t m;
    for (int r = 0; r < 4; r++) begin
      m[r] = mulX(a[r]) ^ mulX(a[(r + 1) % 4]) ^ a[(r + 1) % 4] ^
             a[(r + 2) % 4] ^ a[(r + 3) % 4];
    end
    return m;
  endfunction

  function automatic keySched_t expandKey(block_t key);
    logic [31:0] w [44];
    logic [31:0] t;
    byte_t       rcon;
    keySched_t   ks;
    rcon = 8'h01;
    for (int i = 0; i < 4; i++) begin
      w[i] = key[i];
    end
    for (int i = 4; i < 44; i++) begin
      t = w[i - 1];
      if (i % 4 == 0) begin
        t = {t[23:0], t[31:24]};  // RotWord.
        t = {sboxFwd(t[31:24]), sboxFwd(t[23:16]), sboxFwd(t[15:8]), sboxFwd(t[7:0])} ^
            {rcon, 24'h000000};
        rcon = mulX(rcon);
      end
      w[i] = w[i - 4] ^ t;
    end
    for (int r = 0; r < 11; r++) begin
      for (int c = 0; c < 4; c++) begin
        ks[r][c] = w[4 * r + c];
      end
    end
    return ks;
  endfunction

  function automatic block_t encryptBlock(block_t plain, keySched_t ks);
    block_t s;
    block_t t;
    s = plain ^ ks[0];
    for (int rnd = 1; rnd <= 10; rnd++) begin
      for (int c = 0; c < 4; c++) begin
        for (int r = 0; r < 4; r++) begin
          t[c][r] = sboxFwd(s[(c + r) % 4][r]);  // SubBytes and ShiftRows.
        end
      end
      if (rnd < 10) begin
        for (int c = 0; c < 4; c++) begin
          t[c] = mixColumn(t[c]);
        end
      end
      s = t ^ ks[rnd];
    end
    return s;
  endfunction

endpackage

// ==== verilog/aesCtrlPkg.sv ====
package aesCtrlPkg;

  // Controller states for one block.
  typedef enum logic [1:0] {
    sIdle,  // Waiting for req.
    sRound, // Running the middle rounds and the last round.
    sDone   // Result is valid and ack stays high until req drops.
  } ctrlState_e;

  // Opcodes that steer the round datapath.
  typedef enum logic [1:0] {
    opHold,      // Keep the state.
    opLoad,      // Load cipherIn xor the last round key.
    opMidRound,  // Full inverse round with InvMixColumns.
    opLastRound  // Final round without InvMixColumns.
  } roundOp_e;

endpackage

// ==== verilog/aesDecryptTop.sv ====
`timescale 1ns/1ns

module aesDecryptTop (
  input  logic                        clk,
  input  logic                        rstN,
  input  aesTypesPkg::roundKeyWrite_t keyWr,
  input  logic                        req,
  input  aesTypesPkg::block_t         cipherIn,
  output logic                        ack,
  output aesTypesPkg::block_t         plainOut
);
  import aesTypesPkg::*;
  import aesCtrlPkg::*;

  roundOp_e op;
  keyIdx_t  keyIdx;
  block_t   rdKey;

  // ####################################################################
  // Sequencer.
  decryptControl ctrl_i (
    .clk    (clk),
    .rstN   (rstN),
    .req    (req),
    .ack    (ack),
    .op     (op),
    .keyIdx (keyIdx)
  );

  // ####################################################################
  // Round keys that the host writes while the core is idle.
  roundKeyStore keys_i (
    .clk   (clk),
    .rstN  (rstN),
    .keyWr (keyWr),
    .rdIdx (keyIdx),
    .rdKey (rdKey)
  );

  // ####################################################################
  // State register and one inverse round.
  invRoundData data_i (
    .clk      (clk),
    .rstN     (rstN),
    .op       (op),
    .inBlock  (cipherIn),
    .roundKey (rdKey),
    .stateOut (plainOut)
  );

endmodule

// ==== verilog/aesTypesPkg.sv ====
package aesTypesPkg;

  // One element of GF(2^8).
  typedef logic [7:0] byte_t;

  // A state column; row 0 sits in the most significant byte.
  typedef byte_t [0:3] column_t;

  // Full block in FIPS-197 byte order with column 0 in the top 32 bits.
  typedef column_t [0:3] block_t;

  // Round-key index from 0 to 10.
  typedef logic [3:0] keyIdx_t;

  // Host write into the key store.
  typedef struct packed {
    logic    en;
    keyIdx_t idx;
    block_t  key;
  } roundKeyWrite_t;

  // ####################################################################
  // Multiply by x modulo the AES polynomial x^8 + x^4 + x^3 + x + 1.
  function automatic byte_t xtime(byte_t b);
    return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
  endfunction

endpackage

// ==== verilog/decryptControl.sv ====
`timescale 1ns/1ns
`include "aesDec_consts.svh"

module decryptControl (
  input  logic                 clk,
  input  logic                 rstN,
  input  logic                 req,
  output logic                 ack,
  output aesCtrlPkg::roundOp_e op,
  output aesTypesPkg::keyIdx_t keyIdx
);
  import aesTypesPkg::*;
  import aesCtrlPkg::*;

  ctrlState_e stateQ;
  ctrlState_e stateD;
  keyIdx_t    cntQ;     // Key index of the round running now.
  keyIdx_t    cntD;

  // ####################################################################
  // Next state and outputs.
  always_comb begin
    stateD = stateQ;
    cntD   = cntQ;
    op     = opHold;
    keyIdx = cntQ;

    case (stateQ)
      sIdle: begin
        keyIdx = keyIdx_t'(`AES_ROUNDS);  // Decryption starts with the last key.
        if (req) begin
          op     = opLoad;
          stateD = sRound;
          cntD   = keyIdx_t'(`AES_ROUNDS - 1);
        end
      end

      sRound: begin
        if (cntQ == '0) begin
          op     = opLastRound;
          stateD = sDone;
        end else begin
          op   = opMidRound;
          cntD = cntQ - keyIdx_t'(1);
        end
      end

      sDone: begin
        // Hold the result until the host lets go of req.
        if (!req) begin
          stateD = sIdle;
        end
      end

      default: stateD = sIdle;
    endcase
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      stateQ <= sIdle;
      cntQ   <= '0;
    end else begin
      stateQ <= stateD;
      cntQ   <= cntD;
    end
  end

  assign ack = (stateQ == sDone);

  // Four-phase rule. The host keeps req high until it has seen ack.
  property pReqHeldInRound;
    @(posedge clk) disable iff (!rstN)
      (stateQ == sRound) |-> req;
  endproperty
  aReqHeldInRound: assert property (pReqHeldInRound)
    else $error("req dropped before ack, round key %0d", cntQ);

endmodule

// ==== verilog/invMixColumn.sv ====
`timescale 1ns/1ns

module invMixColumn (
  input  aesTypesPkg::column_t inColumn,
  output aesTypesPkg::column_t outColumn
);
  import aesTypesPkg::*;

  // ####################################################################
  // Constant multipliers built from xtime chains.

  function automatic byte_t mul9(byte_t b);
    byte_t x8;
    x8 = xtime(xtime(xtime(b)));
    return x8 ^ b;
  endfunction

  function automatic byte_t mul11(byte_t b);
    byte_t x2;
    byte_t x8;
    x2 = xtime(b);
    x8 = xtime(xtime(x2));
    return x8 ^ x2 ^ b;
  endfunction

  function automatic byte_t mul13(byte_t b);
    byte_t x4;
    byte_t x8;
    x4 = xtime(xtime(b));
    x8 = xtime(x4);
    return x8 ^ x4 ^ b;
  endfunction

  function automatic byte_t mul14(byte_t b);
    byte_t x2;
    byte_t x4;
    byte_t x8;
    x2 = xtime(b);
    x4 = xtime(x2);
    x8 = xtime(x4);
    return x8 ^ x4 ^ x2;
  endfunction

  // ####################################################################
  // Each row uses the 0e 0b 0d 09 row, rotated right by the row number.
  for (genvar r = 0; r < 4; r++) begin : gRow
    assign outColumn[r] = mul14(inColumn[r]) ^
                          mul11(inColumn[(r + 1) % 4]) ^
                          mul13(inColumn[(r + 2) % 4]) ^
                          mul9(inColumn[(r + 3) % 4]);
  end

endmodule

// ==== verilog/invRoundData.sv ====
`timescale 1ns/1ns

module invRoundData (
  input  logic                 clk,
  input  logic                 rstN,
  input  aesCtrlPkg::roundOp_e op,
  input  aesTypesPkg::block_t  inBlock,
  input  aesTypesPkg::block_t  roundKey,
  output aesTypesPkg::block_t  stateOut
);
  import aesTypesPkg::*;
  import aesCtrlPkg::*;

  block_t stateQ;
  block_t shifted;  // After InvShiftRows.
  block_t subbed;   // After InvSubBytes.
  block_t keyed;    // After AddRoundKey.
  block_t mixed;    // After InvMixColumns.

  // ####################################################################
  // Round datapath.

  // Row r moves right by r columns.
  for (genvar c = 0; c < 4; c++) begin : gCol
    for (genvar r = 0; r < 4; r++) begin : gRow
      assign shifted[c][r] = stateQ[(c + 4 - r) % 4][r];

      invSbox sbox_i (
        .inByte  (shifted[c][r]),
        .outByte (subbed[c][r])
      );
    end

    invMixColumn mix_i (
      .inColumn  (keyed[c]),
      .outColumn (mixed[c])
    );
  end

  assign keyed = subbed ^ roundKey;

  // ####################################################################
  // State register.
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      stateQ <= '0;
    end else begin
      case (op)
        opLoad:      stateQ <= inBlock ^ roundKey;  // Initial AddRoundKey.
        opMidRound:  stateQ <= mixed;
        opLastRound: stateQ <= keyed;
        default:     stateQ <= stateQ;
      endcase
    end
  end

  assign stateOut = stateQ;

  // A round opcode only ever continues a block that was loaded.
  property pRoundFollowsLoad;
    @(posedge clk) disable iff (!rstN)
      (op inside {opMidRound, opLastRound}) |-> ($past(op) inside {opLoad, opMidRound});
  endproperty
  aRoundFollowsLoad: assert property (pRoundFollowsLoad)
    else $error("Round opcode %s out of sequence", op.name());

endmodule

// ==== verilog/invSbox.sv ====
`timescale 1ns/1ns

module invSbox (
  input  aesTypesPkg::byte_t inByte,
  output aesTypesPkg::byte_t outByte
);
  import aesTypesPkg::*;

  byte_t affOut;
  byte_t power;
  byte_t inverse;

  // Carry-less product reduced by the AES polynomial.
  function automatic byte_t gfMul(byte_t a, byte_t b);
    byte_t acc;
    byte_t term;
    acc  = '0;
    term = a;
    for (int i = 0; i < 8; i++) begin
      if (b[i]) begin
        acc = acc ^ term;
      end
      term = xtime(term);
    end
    return acc;
  endfunction

  // ####################################################################
  // Inverse affine map. Undoes the forward matrix and the 0x63 constant.
  assign affOut = {inByte[6:0], inByte[7]} ^
                  {inByte[4:0], inByte[7:5]} ^
                  {inByte[1:0], inByte[7:2]} ^
                  8'h05;

  // a^254 = a^2 * a^4 * ... * a^128, which is the inverse for a nonzero a.
  // A zero input stays zero since every factor is zero.
  always_comb begin
    power   = affOut;
    inverse = 8'h01;
    for (int k = 1; k < 8; k++) begin
      power   = gfMul(power, power);    // Now a^(2^k).
      inverse = gfMul(inverse, power);
    end
  end

  assign outByte = inverse;

endmodule

// ==== verilog/roundKeyStore.sv ====
`timescale 1ns/1ns
`include "aesDec_consts.svh"

module roundKeyStore (
  input  logic                        clk,
  input  logic                        rstN,
  input  aesTypesPkg::roundKeyWrite_t keyWr,
  input  aesTypesPkg::keyIdx_t        rdIdx,
  output aesTypesPkg::block_t         rdKey
);
  import aesTypesPkg::*;

  logic [`AES_BLOCK_BITS-1:0] keyMem [`AES_NUM_KEYS];

  // ####################################################################
  // Host write port.
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      keyMem <= '{default: '0};
    end else if (keyWr.en && (keyWr.idx < `AES_NUM_KEYS)) begin
      keyMem[keyWr.idx] <= keyWr.key;
    end
  end

  // Read is combinational so the key lines up with the opcode in the same cycle.
  always_comb begin
    if (rdIdx < `AES_NUM_KEYS) begin
      rdKey = keyMem[rdIdx];
    end else begin
      rdKey = '0;  // Unused indices read as zero.
    end
  end

  // The host only names existing entries.
  property pWriteInRange;
    @(posedge clk) disable iff (!rstN)
      keyWr.en |-> (keyWr.idx < `AES_NUM_KEYS);
  endproperty
  aWriteInRange: assert property (pWriteInRange)
    else $error("Round key write to index %0d", keyWr.idx);

endmodule
